/* common/bridge_defines.svh */
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// cpu side word, used for both address and data
`define BRIDGE_WORD_W 32

// word address on the sram pins
// cpu address bits 21..2 map onto it
`define BRIDGE_SRAM_ADDR_W 20

// one enable per byte lane
`define BRIDGE_BE_W 4

// width of a serial data byte
`define BRIDGE_UART_BYTE_W 8

// address bit picking extram over baseram
`define BRIDGE_CHIP_SEL_BIT 22

// top address byte of the serial region
`define BRIDGE_UART_REGION 8'hBF

// low nibble of the status word inside the serial region
// any other offset is the data byte
`define BRIDGE_UART_STATUS_OFS 4'hC

`endif

/* common/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

    `include "bridge_defines.svh"

    // plain vectors with a meaning
    typedef logic [`BRIDGE_WORD_W-1:0] word_t;
    typedef logic [`BRIDGE_SRAM_ADDR_W-1:0] sram_addr_t;
    // active high on the cpu side, inverted on the pins
    typedef logic [`BRIDGE_BE_W-1:0] byte_en_t;
    typedef logic [`BRIDGE_UART_BYTE_W-1:0] uart_byte_t;

    // data port command, held by the cpu until ack
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic we;
        byte_en_t be;
    } cpu_req_t;

    // everything one sram chip needs for one cycle
    typedef struct packed {
        sram_addr_t addr;
        // active low lane enables
        byte_en_t be_n;
        logic ce_n;
        logic oe_n;
        logic we_n;
        // put wdata on the shared bus
        logic drive;
        word_t wdata;
    } sram_cmd_t;

    // cpld uart sequencer
    typedef enum logic [2:0] {
        IDLE,
        TX_PULSE,
        WAIT_TBRE,
        WAIT_TSRE,
        RX_WAIT,
        RX_PULSE,
        DONE
    } uart_state_e;

endpackage

`default_nettype wire

/* sram/sram_port.sv */
`default_nettype none

module sram_port import bridge_pkg::*; (
    input wire clk_11M0592,
    input wire reset_btn,
    input sram_cmd_t cmd_i,
    output word_t rdata_o,
    inout wire word_t ram_data_io,
    output sram_addr_t ram_addr_o,
    output byte_en_t ram_be_n_o,
    output logic ram_ce_n_o,
    output logic ram_oe_n_o,
    output logic ram_we_n_o
);

    // low during reset and its last edge
    logic live_q;

    always_ff @(posedge clk_11M0592) begin
        if (reset_btn) begin
            live_q <= 1'b0;
        end else begin
            live_q <= 1'b1;
        end
    end

    // address and lanes pass straight to the pins
    assign ram_addr_o = cmd_i.addr;
    assign ram_be_n_o = cmd_i.be_n;

    // strobes parked high until the port is live
    always_comb begin
        ram_ce_n_o = 1'b1;
        ram_oe_n_o = 1'b1;
        ram_we_n_o = 1'b1;
        if (live_q) begin
            ram_ce_n_o = cmd_i.ce_n;
            ram_oe_n_o = cmd_i.oe_n;
            ram_we_n_o = cmd_i.we_n;
        end
    end

    // tristate driver
    // a serial write drives the bus with ce_n still high
    assign ram_data_io = (live_q && cmd_i.drive) ? cmd_i.wdata : 'z;

    // whatever sits on the bus, chip read or cpld byte
    assign rdata_o = ram_data_io;

endmodule

`default_nettype wire

/* uart/uart_cpld_ctrl.sv */
`default_nettype none

module uart_cpld_ctrl import bridge_pkg::*; (
    input wire clk_11M0592,
    input wire reset_btn,
    // level request from the arbiter, one access at a time
    input wire req_i,
    input wire we_i,
    input wire uart_dataready_i,
    input wire uart_tbre_i,
    input wire uart_tsre_i,
    // low lane of the baseram bus
    input uart_byte_t bus_byte_i,
    output logic done_o,
    output uart_byte_t rbyte_o,
    output logic uart_rdn_o,
    output logic uart_wrn_o
);

    uart_state_e state_q;
    uart_state_e state_d;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // pick direction from the held request
                if (req_i) begin
                    if (we_i) begin
                        state_d = TX_PULSE;
                    end else begin
                        state_d = RX_WAIT;
                    end
                end
            end
            TX_PULSE: begin
                // single cycle write strobe
                state_d = WAIT_TBRE;
            end
            WAIT_TBRE: begin
                // cpld took the byte into its buffer
                if (uart_tbre_i) begin
                    state_d = WAIT_TSRE;
                end
            end
            WAIT_TSRE: begin
                // shift register empty, byte is out on the line
                if (uart_tsre_i) begin
                    state_d = DONE;
                end
            end
            RX_WAIT: begin
                if (uart_dataready_i) begin
                    state_d = RX_PULSE;
                end
            end
            RX_PULSE: begin
                state_d = DONE;
            end
            DONE: begin
                // request still high here, not a new one
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_11M0592) begin
        if (reset_btn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // strobes registered from the next state
    // so each is low exactly for its pulse state, no glitches on the pins
    always_ff @(posedge clk_11M0592) begin
        if (reset_btn) begin
            uart_wrn_o <= 1'b1;
            uart_rdn_o <= 1'b1;
        end else begin
            uart_wrn_o <= state_d != TX_PULSE;
            uart_rdn_o <= state_d != RX_PULSE;
        end
    end

    // cpld drives the byte while rdn is low
    // sample it on the edge that ends the pulse
    always_ff @(posedge clk_11M0592) begin
        if (state_q == RX_PULSE) begin
            rbyte_o <= bus_byte_i;
        end
    end

    // one cycle, the arbiter acks the cpu here
    assign done_o = state_q == DONE;

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
`default_nettype none

`include "bridge_defines.svh"

module mem_arbiter import bridge_pkg::*; (
    input wire clk_11M0592,
    input wire reset_btn,
    input wire data_req_i,
    input cpu_req_t data_cmd_i,
    input wire instr_req_i,
    input word_t instr_addr_i,
    input word_t base_rdata_i,
    input word_t ext_rdata_i,
    input wire uart_done_i,
    input uart_byte_t uart_rbyte_i,
    input wire uart_dataready_i,
    input wire uart_tsre_i,
    output sram_cmd_t base_cmd_o,
    output sram_cmd_t ext_cmd_o,
    output logic uart_req_o,
    output logic uart_we_o,
    output uart_byte_t uart_wbyte_o,
    output word_t data_rdata_o,
    output logic data_ack_o,
    output word_t instr_rdata_o,
    output logic instr_ack_o
);

    // chip deselected, bus released
    localparam sram_cmd_t sram_idle = '{
        addr: '0, be_n: '1, ce_n: 1'b1, oe_n: 1'b1, we_n: 1'b1, drive: 1'b0, wdata: '0
    };

    logic data_is_uart;
    logic data_is_status;
    logic done_q;

    // one selected chip access, reads leave the bus floating
    function automatic sram_cmd_t sram_access(input word_t addr, input byte_en_t be,
                                              input logic we, input word_t wdata);
        sram_cmd_t cmd;
        cmd.addr = addr[`BRIDGE_SRAM_ADDR_W+1:2];
        cmd.be_n = ~be;
        cmd.ce_n = 1'b0;
        cmd.oe_n = we;
        cmd.we_n = ~we;
        cmd.drive = we;
        cmd.wdata = wdata;
        return cmd;
    endfunction

    // region code in the top address byte
    assign data_is_uart = data_cmd_i.addr[`BRIDGE_WORD_W-1 -: 8] == `BRIDGE_UART_REGION;
    assign data_is_status = data_is_uart && data_cmd_i.addr[3:0] == `BRIDGE_UART_STATUS_OFS;

    assign uart_we_o = data_cmd_i.we;
    assign uart_wbyte_o = data_cmd_i.wdata[7:0];

    // high in the cycle after done
    // keeps a late request from restarting the sequencer
    always_ff @(posedge clk_11M0592) begin
        if (reset_btn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= uart_done_i;
        end
    end

    always_comb begin
        base_cmd_o = sram_idle;
        ext_cmd_o = sram_idle;
        uart_req_o = 1'b0;
        data_rdata_o = '0;
        data_ack_o = 1'b0;
        instr_rdata_o = '0;
        instr_ack_o = 1'b0;
        if (data_req_i) begin
            if (data_is_status) begin
                // status answers at once
                data_rdata_o = word_t'({uart_dataready_i, uart_tsre_i});
                data_ack_o = 1'b1;
            end else if (data_is_uart) begin
                // level request until the sequencer reports done
                uart_req_o = !uart_done_i && !done_q;
                data_ack_o = uart_done_i;
                data_rdata_o = word_t'(uart_rbyte_i);
                if (data_cmd_i.we) begin
                    // byte on the shared bus for the cpld, chip stays off
                    base_cmd_o.drive = 1'b1;
                    base_cmd_o.wdata = word_t'(uart_wbyte_o);
                end
            end else if (data_cmd_i.addr[`BRIDGE_CHIP_SEL_BIT]) begin
                ext_cmd_o = sram_access(data_cmd_i.addr, data_cmd_i.be,
                                        data_cmd_i.we, data_cmd_i.wdata);
                data_rdata_o = ext_rdata_i;
                data_ack_o = 1'b1;
            end else begin
                base_cmd_o = sram_access(data_cmd_i.addr, data_cmd_i.be,
                                         data_cmd_i.we, data_cmd_i.wdata);
                data_rdata_o = base_rdata_i;
                data_ack_o = 1'b1;
            end
        end else if (instr_req_i) begin
            // fetch only when the data port is quiet, full word
            if (instr_addr_i[`BRIDGE_CHIP_SEL_BIT]) begin
                ext_cmd_o = sram_access(instr_addr_i, '1, 1'b0, '0);
                instr_rdata_o = ext_rdata_i;
            end else begin
                base_cmd_o = sram_access(instr_addr_i, '1, 1'b0, '0);
                instr_rdata_o = base_rdata_i;
            end
            instr_ack_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/bus_bridge_top.sv */
`default_nettype none

module bus_bridge_top import bridge_pkg::*; (
    input wire clk_11M0592,
    input wire reset_btn,

    // data port, read and write
    input wire data_req_i,
    input cpu_req_t data_cmd_i,
    output word_t data_rdata_o,
    output logic data_ack_o,

    // instruction port, read only
    input wire instr_req_i,
    input word_t instr_addr_i,
    output word_t instr_rdata_o,
    output logic instr_ack_o,

    // baseram, low byte shared with the cpld uart
    inout wire word_t base_ram_data_io,
    output sram_addr_t base_ram_addr_o,
    output byte_en_t base_ram_be_n_o,
    output logic base_ram_ce_n_o,
    output logic base_ram_oe_n_o,
    output logic base_ram_we_n_o,

    // extram
    inout wire word_t ext_ram_data_io,
    output sram_addr_t ext_ram_addr_o,
    output byte_en_t ext_ram_be_n_o,
    output logic ext_ram_ce_n_o,
    output logic ext_ram_oe_n_o,
    output logic ext_ram_we_n_o,

    // cpld uart
    output logic uart_rdn_o,
    output logic uart_wrn_o,
    input wire uart_dataready_i,
    input wire uart_tbre_i,
    input wire uart_tsre_i
);

    sram_cmd_t base_cmd;
    sram_cmd_t ext_cmd;
    word_t base_rdata;
    word_t ext_rdata;
    logic uart_req;
    logic uart_we;
    logic uart_done;
    uart_byte_t uart_rbyte;

    // decode, priority and read data return
    // the write byte reaches the cpld over the baseram bus, so uart_wbyte_o stays open
    mem_arbiter u_mem_arbiter (
        .clk_11M0592(clk_11M0592), .reset_btn(reset_btn),
        .data_req_i(data_req_i), .data_cmd_i(data_cmd_i),
        .instr_req_i(instr_req_i), .instr_addr_i(instr_addr_i),
        .base_rdata_i(base_rdata), .ext_rdata_i(ext_rdata),
        .uart_done_i(uart_done), .uart_rbyte_i(uart_rbyte),
        .uart_dataready_i(uart_dataready_i), .uart_tsre_i(uart_tsre_i),
        .base_cmd_o(base_cmd), .ext_cmd_o(ext_cmd),
        .uart_req_o(uart_req), .uart_we_o(uart_we), .uart_wbyte_o(),
        .data_rdata_o(data_rdata_o), .data_ack_o(data_ack_o),
        .instr_rdata_o(instr_rdata_o), .instr_ack_o(instr_ack_o)
    );

    sram_port u_base_port (
        .clk_11M0592(clk_11M0592), .reset_btn(reset_btn), .cmd_i(base_cmd),
        .rdata_o(base_rdata), .ram_data_io(base_ram_data_io),
        .ram_addr_o(base_ram_addr_o), .ram_be_n_o(base_ram_be_n_o),
        .ram_ce_n_o(base_ram_ce_n_o), .ram_oe_n_o(base_ram_oe_n_o),
        .ram_we_n_o(base_ram_we_n_o)
    );

    sram_port u_ext_port (
        .clk_11M0592(clk_11M0592), .reset_btn(reset_btn), .cmd_i(ext_cmd),
        .rdata_o(ext_rdata), .ram_data_io(ext_ram_data_io),
        .ram_addr_o(ext_ram_addr_o), .ram_be_n_o(ext_ram_be_n_o),
        .ram_ce_n_o(ext_ram_ce_n_o), .ram_oe_n_o(ext_ram_oe_n_o),
        .ram_we_n_o(ext_ram_we_n_o)
    );

    // rx byte comes in on the low baseram lane
    uart_cpld_ctrl u_uart_ctrl (
        .clk_11M0592(clk_11M0592), .reset_btn(reset_btn),
        .req_i(uart_req), .we_i(uart_we),
        .uart_dataready_i(uart_dataready_i), .uart_tbre_i(uart_tbre_i),
        .uart_tsre_i(uart_tsre_i), .bus_byte_i(base_ram_data_io[7:0]),
        .done_o(uart_done), .rbyte_o(uart_rbyte),
        .uart_rdn_o(uart_rdn_o), .uart_wrn_o(uart_wrn_o)
    );

endmodule

`default_nettype wire

/* verification/bus_bridge_chk.sv */
`default_nettype none

module bus_bridge_chk (
    input wire clk_11M0592,
    input wire reset_btn,
    input wire uart_rdn_i,
    input wire uart_wrn_i,
    input wire base_ce_n_i,
    input wire base_oe_n_i,
    input wire base_we_n_i,
    input wire ext_ce_n_i,
    input wire ext_oe_n_i,
    input wire ext_we_n_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // cpld bus carries one direction at a time
    a_uart_strobes: assert property (@(posedge clk_11M0592) disable iff (reset_btn)
        uart_rdn_i || uart_wrn_i)
        else $error("uart rdn and wrn low in the same cycle");

    // read and write strobe of one chip never overlap
    a_base_oe_we: assert property (@(posedge clk_11M0592) disable iff (reset_btn)
        base_oe_n_i || base_we_n_i)
        else $error("baseram oe_n and we_n low together");

    a_ext_oe_we: assert property (@(posedge clk_11M0592) disable iff (reset_btn)
        ext_oe_n_i || ext_we_n_i)
        else $error("extram oe_n and we_n low together");

    // one chip per access
    a_one_chip: assert property (@(posedge clk_11M0592) disable iff (reset_btn)
        base_ce_n_i || ext_ce_n_i)
        else $error("baseram and extram selected in the same cycle");

endmodule

bind bus_bridge_top bus_bridge_chk u_bus_bridge_chk (
    .clk_11M0592(clk_11M0592), .reset_btn(reset_btn),
    .uart_rdn_i(uart_rdn_o), .uart_wrn_i(uart_wrn_o),
    .base_ce_n_i(base_ram_ce_n_o), .base_oe_n_i(base_ram_oe_n_o),
    .base_we_n_i(base_ram_we_n_o), .ext_ce_n_i(ext_ram_ce_n_o),
    .ext_oe_n_i(ext_ram_oe_n_o), .ext_we_n_i(ext_ram_we_n_o)
);

`default_nettype wire

/* verification/bus_bridge_tb.sv */
`default_nettype none

`include "bridge_defines.svh"

module bus_bridge_tb import bridge_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LINES = 64;
    localparam int FIELDS = 5;

    logic clk_11M0592 = 1'b0;
    logic reset_btn;
    logic data_req;
    cpu_req_t data_cmd;
    word_t data_rdata;
    logic data_ack;
    logic instr_req;
    word_t instr_addr;
    word_t instr_rdata;
    logic instr_ack;
    wire [31:0] base_ram_data;
    wire [31:0] ext_ram_data;
    sram_addr_t base_ram_addr;
    sram_addr_t ext_ram_addr;
    byte_en_t base_ram_be_n;
    byte_en_t ext_ram_be_n;
    logic base_ram_ce_n;
    logic base_ram_oe_n;
    logic base_ram_we_n;
    logic ext_ram_ce_n;
    logic ext_ram_oe_n;
    logic ext_ram_we_n;
    logic uart_rdn;
    logic uart_wrn;
    logic uart_dataready = 1'b0;
    logic uart_tbre = 1'b1;
    logic uart_tsre = 1'b1;

    // model state
    word_t base_mem [0:1023];
    word_t ext_mem [0:1023];
    uart_byte_t rx_queue [$];
    uart_byte_t rx_byte = '0;
    uart_byte_t tx_byte = '0;
    logic [31:0] rand_state = 32'h3386d0b7;

    word_t pattern [0:FIELDS*MAX_LINES-1];
    int line_count = 0;
    int cycle_count = 0;
    int cycle_limit = 1000;
    int fail_count = 0;
    logic fetch_held = 1'b0;
    word_t fetch_held_exp;

    always #10 clk_11M0592 = ~clk_11M0592;

    bus_bridge_top u_bus_bridge_top (
        .clk_11M0592(clk_11M0592), .reset_btn(reset_btn),
        .data_req_i(data_req), .data_cmd_i(data_cmd),
        .data_rdata_o(data_rdata), .data_ack_o(data_ack),
        .instr_req_i(instr_req), .instr_addr_i(instr_addr),
        .instr_rdata_o(instr_rdata), .instr_ack_o(instr_ack),
        .base_ram_data_io(base_ram_data), .base_ram_addr_o(base_ram_addr),
        .base_ram_be_n_o(base_ram_be_n), .base_ram_ce_n_o(base_ram_ce_n),
        .base_ram_oe_n_o(base_ram_oe_n), .base_ram_we_n_o(base_ram_we_n),
        .ext_ram_data_io(ext_ram_data), .ext_ram_addr_o(ext_ram_addr),
        .ext_ram_be_n_o(ext_ram_be_n), .ext_ram_ce_n_o(ext_ram_ce_n),
        .ext_ram_oe_n_o(ext_ram_oe_n), .ext_ram_we_n_o(ext_ram_we_n),
        .uart_rdn_o(uart_rdn), .uart_wrn_o(uart_wrn),
        .uart_dataready_i(uart_dataready), .uart_tbre_i(uart_tbre), .uart_tsre_i(uart_tsre)
    );

    // async sram reads, selected chip with oe low
    assign base_ram_data = (!base_ram_ce_n && !base_ram_oe_n) ? base_mem[base_ram_addr[9:0]] : 'z;
    assign ext_ram_data = (!ext_ram_ce_n && !ext_ram_oe_n) ? ext_mem[ext_ram_addr[9:0]] : 'z;
    // cpld puts the rx byte on the low baseram lane
    assign base_ram_data[7:0] = (uart_rdn === 1'b0) ? rx_byte : 'z;

    // writes land on the clock edge that completes the request
    always @(posedge clk_11M0592) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (!base_ram_ce_n && !base_ram_we_n && !base_ram_be_n[lane]) begin
                base_mem[base_ram_addr[9:0]][8*lane +: 8] <= base_ram_data[8*lane +: 8];
            end
            if (!ext_ram_ce_n && !ext_ram_we_n && !ext_ram_be_n[lane]) begin
                ext_mem[ext_ram_addr[9:0]][8*lane +: 8] <= ext_ram_data[8*lane +: 8];
            end
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // cpld transmitter, tbre then tsre come back after random gaps
    always @(negedge uart_wrn) begin
        int gap;
        if (!reset_btn) begin
            #2;
            uart_tbre = 1'b0;
            uart_tsre = 1'b0;
            @(posedge uart_wrn);
            tx_byte = base_ram_data[7:0];
            gap = int'((next_rand() >> 16) % 32'd4) + 1;
            repeat (gap) @(posedge clk_11M0592);
            #2 uart_tbre = 1'b1;
            gap = int'((next_rand() >> 16) % 32'd4) + 1;
            repeat (gap) @(posedge clk_11M0592);
            #2 uart_tsre = 1'b1;
        end
    end

    // cpld receiver hands out the oldest queued byte
    always @(negedge uart_rdn) begin
        if (!reset_btn && rx_queue.size() != 0) begin
            #2;
            rx_byte = rx_queue.pop_front();
            uart_dataready = rx_queue.size() != 0;
        end
    end

    always @(posedge clk_11M0592) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: a handshake never completed within %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic compare_value(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            fail_count++;
            $display("ERR %0d ns: %s, got %08h, expected %08h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // starts in the drive slot, returns in the drive slot after the ack edge
    task automatic data_access(input word_t addr, input word_t wdata, input logic we,
                               input byte_en_t be, output word_t rdata);
        data_cmd = '{addr: addr, wdata: wdata, we: we, be: be};
        data_req = 1'b1;
        forever begin
            @(negedge clk_11M0592);
            if (fetch_held) begin
                compare_value(word_t'(instr_ack), '0, "fetch acked while data port busy");
            end
            if (data_ack) begin
                break;
            end
        end
        rdata = data_rdata;
        if (we && addr[31:24] == `BRIDGE_UART_REGION && addr[3:0] != `BRIDGE_UART_STATUS_OFS) begin
            compare_value(word_t'(uart_tsre), 32'd1, "serial write acked before tsre");
        end
        @(posedge clk_11M0592);
        #2;
        data_req = 1'b0;
        // stalled fetch goes through in the first quiet cycle
        if (fetch_held) begin
            @(negedge clk_11M0592);
            compare_value(word_t'(instr_ack), 32'd1, "stalled fetch not acked");
            compare_value(instr_rdata, fetch_held_exp, "stalled fetch data");
            @(posedge clk_11M0592);
            #2;
            instr_req = 1'b0;
            fetch_held = 1'b0;
        end
    endtask

    task automatic fetch_word(input word_t addr, output word_t rdata);
        instr_addr = addr;
        instr_req = 1'b1;
        do @(negedge clk_11M0592); while (!instr_ack);
        rdata = instr_rdata;
        @(posedge clk_11M0592);
        #2;
        instr_req = 1'b0;
    endtask

    initial begin
        word_t addr;
        word_t wdata;
        word_t exp;
        word_t got;
        reset_btn = 1'b1;
        data_req = 1'b0;
        data_cmd = '0;
        instr_req = 1'b0;
        instr_addr = '0;
        // fill follows the whole word address, chips differ
        for (int i = 0; i < 1024; i++) begin
            base_mem[i] = 32'hB500_0000 ^ i;
            ext_mem[i] = 32'hE500_0000 ^ i;
        end
        $readmemh("verification/bus_bridge_patterns.hex", pattern);
        while (line_count < MAX_LINES && !$isunknown(pattern[FIELDS*line_count])) begin
            line_count++;
        end
        if (line_count == 0) begin
            $display("pattern file holds no access lines");
            $display("Simulation FAILED");
            $fatal(1, "no patterns");
        end
        cycle_limit = 40 * line_count + 100;

        repeat (16) @(posedge clk_11M0592);
        #2 reset_btn = 1'b0;
        // idle bus right after reset
        @(negedge clk_11M0592);
        compare_value(word_t'({base_ram_ce_n, base_ram_oe_n, base_ram_we_n, ext_ram_ce_n,
                               ext_ram_oe_n, ext_ram_we_n, uart_rdn, uart_wrn}),
                      32'hFF, "strobes after reset");
        compare_value(word_t'({data_ack, instr_ack}), '0, "acks after reset");
        @(posedge clk_11M0592);
        #2;

        for (int line = 0; line < line_count; line++) begin
            addr = pattern[FIELDS*line+1];
            wdata = pattern[FIELDS*line+2];
            exp = pattern[FIELDS*line+4];
            case (pattern[FIELDS*line][3:0])
                4'h0: data_access(addr, wdata, 1'b1, pattern[FIELDS*line+3][3:0], got);
                4'h1: begin
                    data_access(addr, '0, 1'b0, pattern[FIELDS*line+3][3:0], got);
                    compare_value(got, exp, "data read");
                end
                4'h2: begin
                    fetch_word(addr, got);
                    compare_value(got, exp, "instruction fetch");
                end
                4'h3: begin
                    rx_queue.push_back(wdata[7:0]);
                    uart_dataready = 1'b1;
                end
                4'h4: compare_value(word_t'(tx_byte), exp, "byte seen by uart model");
                4'h5: begin
                    // request stays up until the next data access ends
                    instr_addr = addr;
                    instr_req = 1'b1;
                    fetch_held = 1'b1;
                    fetch_held_exp = exp;
                end
                default: begin
                    $display("pattern line %0d has an unknown operation code", line);
                    $display("Simulation FAILED");
                    $fatal(1, "bad pattern");
                end
            endcase
        end

        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bus_bridge.f */
+incdir+common
common/bridge_pkg.sv
sram/sram_port.sv
uart/uart_cpld_ctrl.sv
design/mem_arbiter.sv
design/bus_bridge_top.sv
verification/bus_bridge_chk.sv
verification/bus_bridge_tb.sv

/* verification/bus_bridge_patterns.hex */
// columns: op address write_data byte_select expected
// op 0 write, 1 read, 2 fetch, 3 queue rx byte, 4 check tx byte, 5 hold a fetch
0 00000010 11223344 3 00000000 // base word 4, low lanes only
1 00000010 00000000 f b5003344
0 00000010 aabbccdd 8 00000000 // top lane only
1 00000010 00000000 f aa003344
0 00400010 cafef00d f 00000000 // bit 22 set, extram word 4
1 00400010 00000000 f cafef00d
1 00000010 00000000 f aa003344 // baseram word 4 untouched
1 00400020 00000000 f e5000008 // untouched extram word
0 00000040 12345678 f 00000000
2 00000040 00000000 f 12345678
2 00400010 00000000 f cafef00d
3 00000000 0000005a 0 00000000
1 bfd003fc 00000000 f 00000003 // byte waiting, tsre high
5 00000040 00000000 f 12345678 // fetch held across the serial read
1 bfd003f8 00000000 f 0000005a
1 bfd003fc 00000000 f 00000001
0 bfd003f8 000000c3 1 00000000
4 00000000 00000000 0 000000c3
5 00400010 00000000 f cafef00d // fetch held across the serial write
0 bfd003f8 0000007e 1 00000000
4 00000000 00000000 0 0000007e
3 00000000 000000a5 0 00000000
1 bfd003fc 00000000 f 00000003
1 bfd003f8 00000000 f 000000a5
1 bfd003fc 00000000 f 00000001
